// ==== sources.f ====
source/mips_id_pkg.sv
source/instruction_decoder.sv
source/register_file.sv
source/main_control.sv
source/branch_address_calculator.sv
source/instruction_decode.sv
testbench/tb_instruction_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_instruction_decode
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_instruction_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_instruction_decode;

    import mips_id_pkg::*;

    logic         i_clock;
    logic         i_reset;
    instr_t       i_instruction;
    addr_t        i_pc_next;
    logic         i_write_enable;
    reg_addr_t    i_write_reg;
    word_t        i_write_data;
    word_t        o_data_a;
    word_t        o_data_b;
    word_t        o_immediate;
    reg_addr_t    o_reg_rs;
    reg_addr_t    o_reg_rt;
    reg_addr_t    o_reg_rd;
    logic         o_reg_dst;
    logic         o_reg_write;
    logic         o_alu_src;
    alu_op_t      o_alu_op;
    logic         o_mem_read;
    logic         o_mem_write;
    logic         o_mem_to_reg;
    logic         o_branch_taken;
    addr_t        o_branch_target;

    word_t        shadow_regs [32];
    word_t        exp_data_a;
    word_t        exp_data_b;
    logic [7:0]   exp_controls;
    logic [7:0]   dut_controls;
    logic         exp_taken;
    addr_t        exp_target;
    logic [31:0]  lfsr_state;
    int           value_errors;
    int           timeout_errors;
    opcode_t      control_ops [9] = '{OP_RTYPE, OP_LW, OP_SW, OP_ADDI, OP_BEQ, OP_BNE,
                                      OP_J, 6'd13, 6'd63};

    instruction_decode #(
        .REG_COUNT (32)
    ) u_dut (.*);

    always #50 i_clock = ~i_clock;

    ////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////
    always @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                shadow_regs[i] <= '0;
            end
        end else if (i_write_enable && (i_write_reg != 5'd0)) begin
            shadow_regs[i_write_reg] <= i_write_data;
        end
    end

    // Bit order {reg_dst, reg_write, alu_src, mem_read, mem_write, mem_to_reg, alu_op}.
    function automatic logic [7:0] expected_controls(input instr_t instr);
        case (instr[31:26])
            OP_RTYPE:       return (instr[5:0] == FUNCT_JR) ? 8'b000000_10 : 8'b110000_10;
            OP_LW:          return 8'b011101_00;
            OP_SW:          return 8'b001010_00;
            OP_ADDI:        return 8'b011000_00;
            OP_BEQ, OP_BNE: return 8'b000000_01;
            default:        return 8'b000000_00;
        endcase
    endfunction

    assign exp_data_a   = shadow_regs[i_instruction[25:21]];
    assign exp_data_b   = shadow_regs[i_instruction[20:16]];
    assign exp_controls = expected_controls(i_instruction);
    assign dut_controls = {o_reg_dst, o_reg_write, o_alu_src, o_mem_read, o_mem_write,
                           o_mem_to_reg, o_alu_op};

    always_comb begin
        exp_taken  = 1'b0;
        exp_target = '0;
        if (i_instruction[31:26] == OP_BEQ || i_instruction[31:26] == OP_BNE) begin
            exp_target = i_pc_next + i_instruction[10:0];
            exp_taken  = (exp_data_a == exp_data_b) == (i_instruction[31:26] == OP_BEQ);
        end else if (i_instruction[31:26] == OP_J) begin
            exp_target = i_instruction[10:0];
            exp_taken  = 1'b1;
        end else if (i_instruction[31:26] == OP_RTYPE && i_instruction[5:0] == FUNCT_JR) begin
            exp_target = exp_data_a[10:0];
            exp_taken  = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////
    task automatic report_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        value_errors++;
        $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
    endtask

    a_data_a: assert property (@(posedge i_clock) disable iff (i_reset)
        o_data_a == exp_data_a)
        else report_value("o_data_a", $sampled(o_data_a), $sampled(exp_data_a));
    a_data_b: assert property (@(posedge i_clock) disable iff (i_reset)
        o_data_b == exp_data_b)
        else report_value("o_data_b", $sampled(o_data_b), $sampled(exp_data_b));
    a_reg_rs: assert property (@(posedge i_clock) disable iff (i_reset)
        o_reg_rs == i_instruction[25:21])
        else report_value("o_reg_rs", 32'($sampled(o_reg_rs)),
                          32'($sampled(i_instruction[25:21])));
    a_reg_rt: assert property (@(posedge i_clock) disable iff (i_reset)
        o_reg_rt == i_instruction[20:16])
        else report_value("o_reg_rt", 32'($sampled(o_reg_rt)),
                          32'($sampled(i_instruction[20:16])));
    a_reg_rd: assert property (@(posedge i_clock) disable iff (i_reset)
        o_reg_rd == i_instruction[15:11])
        else report_value("o_reg_rd", 32'($sampled(o_reg_rd)),
                          32'($sampled(i_instruction[15:11])));
    a_immediate: assert property (@(posedge i_clock) disable iff (i_reset)
        o_immediate == {{16{i_instruction[15]}}, i_instruction[15:0]})
        else report_value("o_immediate", $sampled(o_immediate),
                          {{16{$sampled(i_instruction[15])}}, $sampled(i_instruction[15:0])});
    a_controls: assert property (@(posedge i_clock) disable iff (i_reset)
        dut_controls == exp_controls)
        else report_value("control bits", 32'($sampled(dut_controls)),
                          32'($sampled(exp_controls)));
    a_taken: assert property (@(posedge i_clock) disable iff (i_reset)
        o_branch_taken == exp_taken)
        else report_value("o_branch_taken", 32'($sampled(o_branch_taken)),
                          32'($sampled(exp_taken)));
    a_target: assert property (@(posedge i_clock) disable iff (i_reset)
        o_branch_target == exp_target)
        else report_value("o_branch_target", 32'($sampled(o_branch_target)),
                          32'($sampled(exp_target)));

    ////////////////////////////////////////
    // Stimulus helpers.
    ////////////////////////////////////////
    // Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic apply_instruction(input instr_t instr, input addr_t pc);
        i_instruction = instr;
        i_pc_next     = pc;
        @(negedge i_clock);
    endtask

    task automatic write_register(input reg_addr_t r, input word_t data);
        i_write_enable = 1'b1;
        i_write_reg    = r;
        i_write_data   = data;
        @(negedge i_clock);
        i_write_enable = 1'b0;
    endtask

    task automatic wait_for_read(input reg_addr_t r, input word_t value);
        int cycles;
        cycles = 0;
        i_instruction = {OP_RTYPE, r, 5'd0, 5'd0, 5'd0, 6'd32};
        do begin
            @(negedge i_clock);
            cycles++;
        end while (o_data_a !== value && cycles < 8);
        if (o_data_a !== value) begin
            timeout_errors++;
            $display("Timeout: register %0d never read back the written value", r);
        end
    endtask

    initial begin
        reg_addr_t ra;
        reg_addr_t rb;
        word_t     value;
        instr_t    instr;
        i_clock        = 1'b0;
        i_reset        = 1'b1;
        i_instruction  = '0;
        i_pc_next      = '0;
        i_write_enable = 1'b0;
        i_write_reg    = '0;
        i_write_data   = '0;
        lfsr_state     = 32'd11;
        value_errors   = 0;
        timeout_errors = 0;
        repeat (2) @(negedge i_clock);
        i_reset = 1'b0;

        // All registers read zero after reset.
        for (int k = 0; k < 32; k++) begin
            apply_instruction({OP_RTYPE, 5'(k), 5'(31 - k), 16'd32}, 11'd0);
        end

        // Random writes, then reads of the same register.
        for (int k = 0; k < 40; k++) begin
            ra = 5'(rand_bits(5));
            write_register(ra, rand_bits(32));
            apply_instruction({OP_RTYPE, ra, 5'(rand_bits(5)), 16'd32}, 11'd0);
        end
        write_register(5'd0, 32'hffff_ffff);
        apply_instruction({OP_RTYPE, 5'd0, 5'd0, 16'd32}, 11'd0);
        wait_for_read(ra, shadow_regs[ra]);

        // Control table, unknown opcodes included.
        foreach (control_ops[k]) begin
            apply_instruction({control_ops[k], 20'(rand_bits(20)), 6'd32}, 11'(rand_bits(11)));
        end
        apply_instruction({OP_RTYPE, 20'(rand_bits(20)), FUNCT_JR}, 11'd0);

        // Field slicing, both immediate signs.
        for (int k = 0; k < 24; k++) begin
            instr     = rand_bits(32);
            instr[15] = k[0];
            apply_instruction(instr, 11'(rand_bits(11)));
        end

        // beq and bne on equal and unequal operands.
        for (int k = 0; k < 8; k++) begin
            ra    = 5'(rand_bits(5)) | 5'd1;
            rb    = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
            value = rand_bits(32);
            write_register(ra, value);
            write_register(rb, k[0] ? value : ~value);
            apply_instruction({OP_BEQ, ra, rb, 16'(rand_bits(16))}, 11'(rand_bits(11)));
            apply_instruction({OP_BNE, ra, rb, 16'(rand_bits(16))}, 11'(rand_bits(11)));
        end

        // j and jr.
        for (int k = 0; k < 4; k++) begin
            apply_instruction({OP_J, 26'(rand_bits(26))}, 11'(rand_bits(11)));
            ra = 5'(rand_bits(5)) | 5'd1;
            write_register(ra, rand_bits(32));
            apply_instruction({OP_RTYPE, ra, 15'd0, FUNCT_JR}, 11'(rand_bits(11)));
        end

        @(negedge i_clock);
        $display("Value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/instruction_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module instruction_decode #(
    parameter int REG_COUNT = 32
) (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  mips_id_pkg::instr_t    i_instruction,
    input  mips_id_pkg::addr_t     i_pc_next,
    input  logic                   i_write_enable,
    input  mips_id_pkg::reg_addr_t i_write_reg,
    input  mips_id_pkg::word_t     i_write_data,
    output mips_id_pkg::word_t     o_data_a,
    output mips_id_pkg::word_t     o_data_b,
    output mips_id_pkg::word_t     o_immediate,
    output mips_id_pkg::reg_addr_t o_reg_rs,
    output mips_id_pkg::reg_addr_t o_reg_rt,
    output mips_id_pkg::reg_addr_t o_reg_rd,
    output logic                   o_reg_dst,
    output logic                   o_reg_write,
    output logic                   o_alu_src,
    output mips_id_pkg::alu_op_t   o_alu_op,
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output logic                   o_mem_to_reg,
    output logic                   o_branch_taken,
    output mips_id_pkg::addr_t     o_branch_target
);

    import mips_id_pkg::*;

    logic [25:0]  jump_index;
    branch_kind_e branch_kind;

    instruction_decoder u_instruction_decoder (
        .i_instruction (i_instruction),
        .o_reg_rs      (o_reg_rs),
        .o_reg_rt      (o_reg_rt),
        .o_reg_rd      (o_reg_rd),
        .o_immediate   (o_immediate),
        .o_jump_index  (jump_index),
        .o_branch_kind (branch_kind)
    );

    register_file #(
        .REG_COUNT (REG_COUNT)
    ) u_register_file (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_read_reg_a   (o_reg_rs),
        .i_read_reg_b   (o_reg_rt),
        .i_write_reg    (i_write_reg),
        .i_write_enable (i_write_enable),
        .i_write_data   (i_write_data),
        .o_data_a       (o_data_a),
        .o_data_b       (o_data_b)
    );

    main_control u_main_control (
        .i_instruction (i_instruction),
        .o_reg_dst     (o_reg_dst),
        .o_reg_write   (o_reg_write),
        .o_alu_src     (o_alu_src),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_mem_to_reg  (o_mem_to_reg),
        .o_alu_op      (o_alu_op)
    );

    branch_address_calculator u_branch_address_calculator (
        .i_branch_kind   (branch_kind),
        .i_pc_next       (i_pc_next),
        .i_data_a        (o_data_a),
        .i_data_b        (o_data_b),
        .i_immediate     (o_immediate),
        .i_jump_index    (jump_index),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

endmodule

`default_nettype wire

// ==== source/branch_address_calculator.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_address_calculator (
    input  mips_id_pkg::branch_kind_e i_branch_kind,
    input  mips_id_pkg::addr_t        i_pc_next,
    input  mips_id_pkg::word_t        i_data_a,
    input  mips_id_pkg::word_t        i_data_b,
    input  mips_id_pkg::word_t        i_immediate,
    input  logic [25:0]               i_jump_index,
    output logic                      o_branch_taken,
    output mips_id_pkg::addr_t        o_branch_target
);

    import mips_id_pkg::*;

    addr_t branch_offset;
    addr_t jump_target;
    addr_t reg_target;
    logic  operands_equal;

    // All targets are word addresses truncated to the memory width.
    assign branch_offset  = addr_t'(i_immediate);
    assign jump_target    = addr_t'(i_jump_index);
    assign reg_target     = addr_t'(i_data_a);
    assign operands_equal = (i_data_a == i_data_b);

    ////////////////////////////////////////
    // Target select and taken decision.
    ////////////////////////////////////////
    always_comb begin
        o_branch_taken  = 1'b0;
        o_branch_target = '0;
        case (i_branch_kind)
            BR_EQ: begin
                o_branch_target = i_pc_next + branch_offset;
                o_branch_taken  = operands_equal;
            end
            BR_NE: begin
                o_branch_target = i_pc_next + branch_offset;
                o_branch_taken  = !operands_equal;
            end
            BR_JUMP: begin
                o_branch_target = jump_target;
                o_branch_taken  = 1'b1;
            end
            BR_REG: begin
                o_branch_target = reg_target;
                o_branch_taken  = 1'b1;
            end
            default: begin
                o_branch_taken  = 1'b0;
                o_branch_target = '0;
            end
        endcase
    end

    always_comb begin
        a_taken_kind: assert (!o_branch_taken || (i_branch_kind != BR_NONE))
            else $error("branch taken with no branch kind");
    end

endmodule

`default_nettype wire

// ==== source/main_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module main_control (
    input  mips_id_pkg::instr_t  i_instruction,
    output logic                 o_reg_dst,
    output logic                 o_reg_write,
    output logic                 o_alu_src,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output logic                 o_mem_to_reg,
    output mips_id_pkg::alu_op_t o_alu_op
);

    import mips_id_pkg::*;

    localparam alu_op_t ALU_ADD   = 2'b00;
    localparam alu_op_t ALU_SUB   = 2'b01;
    localparam alu_op_t ALU_FUNCT = 2'b10;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = i_instruction[31:26];
    assign funct  = i_instruction[5:0];

    ////////////////////////////////////////
    // Control table.
    ////////////////////////////////////////
    always_comb begin
        o_reg_dst    = 1'b0;
        o_reg_write  = 1'b0;
        o_alu_src    = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_op     = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                o_alu_op = ALU_FUNCT;
                // jr writes nothing back.
                if (funct != FUNCT_JR) begin
                    o_reg_dst   = 1'b1;
                    o_reg_write = 1'b1;
                end
            end
            OP_LW: begin
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
            end
            OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
            end
            OP_ADDI: begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                o_alu_op = ALU_SUB;
            end
            default: begin
                // j and unknown opcodes.
            end
        endcase
    end

    always_comb begin
        a_mem_excl: assert (!(o_mem_read && o_mem_write))
            else $error("memory read and write requested together");
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file #(
    parameter int REG_COUNT = 32
) (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  mips_id_pkg::reg_addr_t i_read_reg_a,
    input  mips_id_pkg::reg_addr_t i_read_reg_b,
    input  mips_id_pkg::reg_addr_t i_write_reg,
    input  logic                   i_write_enable,
    input  mips_id_pkg::word_t     i_write_data,
    output mips_id_pkg::word_t     o_data_a,
    output mips_id_pkg::word_t     o_data_b
);

    import mips_id_pkg::*;

    word_t regs [REG_COUNT];

    ////////////////////////////////////////
    // Write port.
    ////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write_enable && (i_write_reg != '0)) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    ////////////////////////////////////////
    // Read ports without write-through.
    ////////////////////////////////////////
    assign o_data_a = regs[i_read_reg_a];
    assign o_data_b = regs[i_read_reg_b];

    // Register 0 stays zero on both ports across writes.
    property p_zero_reg_a;
        @(posedge i_clock) disable iff (i_reset)
            (i_read_reg_a == '0) |-> (o_data_a == '0);
    endproperty

    property p_zero_reg_b;
        @(posedge i_clock) disable iff (i_reset)
            (i_read_reg_b == '0) |-> (o_data_b == '0);
    endproperty

    a_zero_reg_a: assert property (p_zero_reg_a)
        else $error("register 0 read nonzero on port a");
    a_zero_reg_b: assert property (p_zero_reg_b)
        else $error("register 0 read nonzero on port b");

endmodule

`default_nettype wire

// ==== source/instruction_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instruction_decoder (
    input  mips_id_pkg::instr_t       i_instruction,
    output mips_id_pkg::reg_addr_t    o_reg_rs,
    output mips_id_pkg::reg_addr_t    o_reg_rt,
    output mips_id_pkg::reg_addr_t    o_reg_rd,
    output mips_id_pkg::word_t        o_immediate,
    output logic [25:0]               o_jump_index,
    output mips_id_pkg::branch_kind_e o_branch_kind
);

    import mips_id_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    imm_t    imm;

    ////////////////////////////////////////
    // Field slicing.
    ////////////////////////////////////////
    assign opcode = i_instruction[31:26];
    assign funct  = i_instruction[5:0];
    assign imm    = i_instruction[15:0];

    assign o_reg_rs     = i_instruction[25:21];
    assign o_reg_rt     = i_instruction[20:16];
    assign o_reg_rd     = i_instruction[15:11];
    assign o_jump_index = i_instruction[25:0];

    // Sign extension to a full word.
    assign o_immediate = {{16{imm[15]}}, imm};

    ////////////////////////////////////////
    // Branch classification.
    ////////////////////////////////////////
    always_comb begin
        case (opcode)
            OP_BEQ: o_branch_kind = BR_EQ;
            OP_BNE: o_branch_kind = BR_NE;
            OP_J:   o_branch_kind = BR_JUMP;
            OP_RTYPE: begin
                // Only jr transfers control among R-type.
                if (funct == FUNCT_JR) begin
                    o_branch_kind = BR_REG;
                end else begin
                    o_branch_kind = BR_NONE;
                end
            end
            default: o_branch_kind = BR_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mips_id_pkg.sv ====
`default_nettype none

package mips_id_pkg;

    ////////////////////////////////////////
    // Widths that carry a meaning.
    ////////////////////////////////////////
    typedef logic [31:0] instr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [10:0] addr_t;
    typedef logic [1:0]  alu_op_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    ////////////////////////////////////////
    // Opcodes and function codes.
    ////////////////////////////////////////
    localparam opcode_t OP_RTYPE = 6'd0;
    localparam opcode_t OP_J     = 6'd2;
    localparam opcode_t OP_BEQ   = 6'd4;
    localparam opcode_t OP_BNE   = 6'd5;
    localparam opcode_t OP_ADDI  = 6'd8;
    localparam opcode_t OP_LW    = 6'd35;
    localparam opcode_t OP_SW    = 6'd43;

    localparam funct_t FUNCT_JR = 6'd8;

    // Kind of control transfer seen by the branch calculator.
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP,
        BR_REG
    } branch_kind_e;

endpackage

`default_nettype wire
